// File: include/quick_spi_params.svh
`ifndef QUICK_SPI_PARAMS_SVH
`define QUICK_SPI_PARAMS_SVH

// AXI side
`define QSPI_DATA_W 32
`define QSPI_ADDR_W 8
`define QSPI_STRB_W 4

// buffer geometry
`define QSPI_MEM_BYTES 64
`define QSPI_WORD_IDX_W 4

// SPI side
`define QSPI_NUM_SLAVES 2
`define QSPI_CNT_W 16

// transmit area with an exclusive end
`define QSPI_TX_START 12
`define QSPI_TX_END 38

`endif

// File: hw/quick_spi_pkg.sv
`include "quick_spi_params.svh"

package quick_spi_pkg;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10 // steps like INCR here
    } axi_burst_e;

    // byte 0 of the buffer
    typedef struct packed {
        logic [3:0] rsvd;
        logic       burst; // one window for all elements
        logic       start; // cleared by the engine when done
        logic       cpha;
        logic       cpol;
    } spi_ctrl_t;

    typedef struct packed {
        logic [`QSPI_CNT_W-1:0] elem_size; // bits per element
        logic [7:0]             slave;
        spi_ctrl_t              ctrl;      // low byte
    } spi_cfg_fields_t;

    // word 0 is stored as bytes and read as fields
    typedef union packed {
        logic [3:0][7:0] bytes;
        spi_cfg_fields_t fields;
    } spi_cfg_word_u;

endpackage

// File: hw/axi_burst_decode.sv
`include "quick_spi_params.svh"

module axi_burst_decode (
    input  logic                        s_axi_aclk,
    input  logic                        s_axi_aresetn,
    input  logic [`QSPI_ADDR_W-1:0]     s_axi_awaddr,
    input  logic [7:0]                  s_axi_awlen,
    input  logic [1:0]                  s_axi_awburst,
    input  logic                        s_axi_awvalid,
    output logic                        s_axi_awready,
    input  logic [`QSPI_DATA_W-1:0]     s_axi_wdata,
    input  logic [`QSPI_STRB_W-1:0]     s_axi_wstrb,
    input  logic                        s_axi_wlast,
    input  logic                        s_axi_wvalid,
    output logic                        s_axi_wready,
    output logic [1:0]                  s_axi_bresp,
    output logic                        s_axi_bvalid,
    input  logic                        s_axi_bready,
    input  logic [`QSPI_ADDR_W-1:0]     s_axi_araddr,
    input  logic [7:0]                  s_axi_arlen,
    input  logic [1:0]                  s_axi_arburst,
    input  logic                        s_axi_arvalid,
    output logic                        s_axi_arready,
    output logic [`QSPI_DATA_W-1:0]     s_axi_rdata,
    output logic [1:0]                  s_axi_rresp,
    output logic                        s_axi_rlast,
    output logic                        s_axi_rvalid,
    input  logic                        s_axi_rready,
    output logic                        wr_en,
    output logic [`QSPI_WORD_IDX_W-1:0] wr_word,
    output logic [`QSPI_DATA_W-1:0]     wr_data,
    output logic [`QSPI_STRB_W-1:0]     wr_strb,
    output logic                        rd_en,
    output logic [`QSPI_WORD_IDX_W-1:0] rd_word,
    input  logic [`QSPI_DATA_W-1:0]     rd_data
);

    logic                      aw_active;
    logic                      ar_active;
    logic [`QSPI_ADDR_W-1:0]   aw_addr;
    logic [`QSPI_ADDR_W-1:0]   ar_addr;
    quick_spi_pkg::axi_burst_e aw_burst;
    quick_spi_pkg::axi_burst_e ar_burst;
    logic [7:0]                aw_len;
    logic [7:0]                ar_len;
    logic [7:0]                aw_cnt;
    logic [7:0]                ar_cnt;
    logic                      bus_idle;
    logic                      aw_start;
    logic                      ar_start;
    logic                      w_last;
    logic                      r_beat;

    function automatic logic [`QSPI_ADDR_W-1:0] next_addr(
        input logic [`QSPI_ADDR_W-1:0] addr,
        input quick_spi_pkg::axi_burst_e burst
    );
        if (burst == quick_spi_pkg::FIXED) begin
            return addr;
        end
        return {addr[`QSPI_ADDR_W-1:2] + 1'b1, 2'b00}; // next word
    endfunction

    // no new burst while a response is still pending
    assign bus_idle = !aw_active && !ar_active && !s_axi_bvalid && !s_axi_rvalid;
    assign aw_start = bus_idle && s_axi_awvalid;
    assign ar_start = bus_idle && s_axi_arvalid && !s_axi_awvalid; // writes first

    assign wr_en   = s_axi_wready && s_axi_wvalid;
    assign w_last  = wr_en && (s_axi_wlast || aw_cnt == aw_len);
    assign wr_word = aw_addr[`QSPI_WORD_IDX_W+1:2];
    assign wr_data = s_axi_wdata;
    assign wr_strb = s_axi_wstrb;

    assign rd_en   = ar_active && !s_axi_rvalid;
    assign r_beat  = s_axi_rvalid && s_axi_rready;
    assign rd_word = ar_addr[`QSPI_WORD_IDX_W+1:2];

    assign s_axi_rdata = rd_data;
    assign s_axi_bresp = 2'b00;
    assign s_axi_rresp = 2'b00;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            aw_active     <= 1'b0;
            aw_cnt        <= '0;
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_bvalid  <= 1'b0;
        end else begin
            s_axi_awready <= aw_start; // single-cycle pulse
            if (aw_start) begin
                aw_active <= 1'b1;
                aw_cnt    <= '0;
            end else if (wr_en) begin
                aw_cnt <= aw_cnt + 1'b1;
                if (w_last) begin
                    aw_active <= 1'b0;
                end
            end
            if (w_last) begin
                s_axi_wready <= 1'b0;
            end else if (aw_active && s_axi_wvalid) begin
                s_axi_wready <= 1'b1;
            end
            if (w_last) begin
                s_axi_bvalid <= 1'b1;
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            ar_active     <= 1'b0;
            ar_cnt        <= '0;
            s_axi_arready <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            s_axi_rlast   <= 1'b0;
        end else begin
            s_axi_arready <= ar_start;
            if (ar_start) begin
                ar_active <= 1'b1;
                ar_cnt    <= '0;
            end else if (r_beat) begin
                ar_cnt <= ar_cnt + 1'b1;
                if (s_axi_rlast) begin
                    ar_active <= 1'b0;
                end
            end
            // buffer word lands together with rvalid
            if (rd_en) begin
                s_axi_rvalid <= 1'b1;
                s_axi_rlast  <= (ar_cnt == ar_len);
            end else if (r_beat) begin
                s_axi_rvalid <= 1'b0;
                s_axi_rlast  <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (aw_start) begin
            aw_addr  <= s_axi_awaddr;
            aw_burst <= quick_spi_pkg::axi_burst_e'(s_axi_awburst);
            aw_len   <= s_axi_awlen;
        end else if (wr_en) begin
            aw_addr <= next_addr(aw_addr, aw_burst);
        end
        if (ar_start) begin
            ar_addr  <= s_axi_araddr;
            ar_burst <= quick_spi_pkg::axi_burst_e'(s_axi_arburst);
            ar_len   <= s_axi_arlen;
        end else if (r_beat) begin
            ar_addr <= next_addr(ar_addr, ar_burst);
        end
    end

endmodule

// File: hw/spi_buffer_mem.sv
`include "quick_spi_params.svh"

module spi_buffer_mem (
    input  logic                          s_axi_aclk,
    input  logic                          s_axi_aresetn,
    input  logic                          wr_en,
    input  logic [`QSPI_WORD_IDX_W-1:0]   wr_word,
    input  logic [`QSPI_DATA_W-1:0]       wr_data,
    input  logic [`QSPI_STRB_W-1:0]       wr_strb,
    input  logic                          rd_en,
    input  logic [`QSPI_WORD_IDX_W-1:0]   rd_word,
    input  logic [`QSPI_WORD_IDX_W+1:0]   tx_byte_idx,
    input  logic                          xfer_done,
    output logic [`QSPI_DATA_W-1:0]       rd_data,
    output quick_spi_pkg::spi_cfg_word_u  cfg_word,
    output logic [`QSPI_CNT_W-1:0]        elem_count,
    output logic [`QSPI_CNT_W-1:0]        extra_toggles,
    output logic [7:0]                    tx_byte
);

    quick_spi_pkg::spi_ctrl_t ctrl_q;                 // byte 0
    logic [7:0]               mem [1:`QSPI_MEM_BYTES-1];
    logic [6:0]               tx_addr;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            ctrl_q <= '0;
        end else if (wr_en && wr_word == '0 && wr_strb[0]) begin
            ctrl_q <= wr_data[7:0];                   // host write wins over done
        end else if (xfer_done) begin
            ctrl_q.start <= 1'b0;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (wr_en) begin
            for (int b = 0; b < `QSPI_STRB_W; b++) begin
                if (wr_strb[b] && {wr_word, 2'(b)} != '0) begin
                    mem[{wr_word, 2'(b)}] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (rd_en) begin
            if (rd_word == '0) begin
                rd_data <= cfg_word;
            end else begin
                for (int b = 0; b < `QSPI_STRB_W; b++) begin
                    rd_data[8*b +: 8] <= mem[{rd_word, 2'(b)}];
                end
            end
        end
    end

    assign cfg_word.bytes = {mem[3], mem[2], mem[1], ctrl_q};
    assign elem_count     = {mem[5], mem[4]};
    assign extra_toggles  = {mem[9], mem[8]};

    // reads past the transmit area give zeros
    assign tx_addr = 7'(`QSPI_TX_START) + 7'(tx_byte_idx);
    assign tx_byte = (tx_addr < 7'(`QSPI_TX_END)) ? mem[tx_addr] : 8'h00;

endmodule

// File: hw/spi_shift_engine.sv
`include "quick_spi_params.svh"

module spi_shift_engine (
    input  logic                          s_axi_aclk,
    input  logic                          s_axi_aresetn,
    input  logic                          hold,
    input  quick_spi_pkg::spi_cfg_word_u  cfg_word,
    input  logic [`QSPI_CNT_W-1:0]        elem_count,
    input  logic [`QSPI_CNT_W-1:0]        extra_toggles,
    input  logic [7:0]                    tx_byte,
    output logic [`QSPI_WORD_IDX_W+1:0]   tx_byte_idx,
    output logic                          xfer_done,
    output logic                          sclk,
    output logic                          mosi,
    output logic [`QSPI_NUM_SLAVES-1:0]   ss_n
);

    typedef enum logic [2:0] {IDLE, SELECT, SHIFT, EXTRA, DESELECT} state_e;

    state_e                 state;
    logic [`QSPI_CNT_W-1:0] bit_cnt;   // bits done in this element
    logic [`QSPI_CNT_W-1:0] elem_cnt;
    logic [`QSPI_CNT_W-1:0] tgl_cnt;
    logic [2:0]             bit_pos;
    logic                   mosi_q;
    logic                   mosi_oe;
    logic                   cpol;
    logic                   cpha;
    logic                   lead;
    logic                   elem_end;
    logic                   win_end;
    logic                   load;

    assign cpol = cfg_word.fields.ctrl.cpol;
    assign cpha = cfg_word.fields.ctrl.cpha;

    // sclk at rest level means the next toggle is a leading edge
    assign lead     = (sclk == cpol);
    assign elem_end = !lead && (bit_cnt == cfg_word.fields.elem_size - 1'b1);
    assign win_end  = elem_end &&
                      (!cfg_word.fields.ctrl.burst || elem_cnt == elem_count - 1'b1);

    // cpha 0 puts bit 0 out at select, later bits on trailing edges
    assign load = (state == SELECT && !cpha) ||
                  (state == SHIFT && (lead ? cpha : (!cpha && !win_end)));

    assign xfer_done = (state == DESELECT) && (elem_cnt == elem_count) && !hold;
    assign mosi      = mosi_oe ? mosi_q : 1'bz;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state    <= IDLE;
            sclk     <= 1'b0;
            ss_n     <= '1;
            mosi_oe  <= 1'b0;
            bit_cnt  <= '0;
            elem_cnt <= '0;
            tgl_cnt  <= '0;
        end else if (!hold) begin
            case (state)
                IDLE: begin
                    sclk     <= cpol;
                    bit_cnt  <= '0;
                    elem_cnt <= '0;
                    if (cfg_word.fields.ctrl.start) begin
                        state <= SELECT;
                    end
                end
                SELECT: begin
                    ss_n    <= ~(`QSPI_NUM_SLAVES'(1) << cfg_word.fields.slave);
                    mosi_oe <= 1'b1;
                    tgl_cnt <= '0;
                    state   <= SHIFT;
                end
                SHIFT: begin
                    sclk <= ~sclk;
                    if (!lead) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (elem_end) begin
                            bit_cnt  <= '0;
                            elem_cnt <= elem_cnt + 1'b1;
                        end
                        if (win_end) begin
                            state <= (extra_toggles == '0) ? DESELECT : EXTRA;
                        end
                    end
                end
                EXTRA: begin
                    sclk    <= ~sclk;  // mosi holds its last bit
                    tgl_cnt <= tgl_cnt + 1'b1;
                    if (tgl_cnt == extra_toggles - 1'b1) begin
                        state <= DESELECT;
                    end
                end
                DESELECT: begin
                    sclk    <= cpol;
                    ss_n    <= '1;
                    mosi_oe <= 1'b0;
                    state   <= (elem_cnt == elem_count) ? IDLE : SELECT;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // LSB-first walk through the transmit bytes
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            bit_pos     <= '0;
            tx_byte_idx <= '0;
        end else if (!hold) begin
            if (state == IDLE) begin
                bit_pos     <= '0;
                tx_byte_idx <= '0;
            end else if (load) begin
                bit_pos <= bit_pos + 1'b1;
                if (bit_pos == 3'd7) begin
                    tx_byte_idx <= tx_byte_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!hold && load) begin
            mosi_q <= tx_byte[bit_pos];
        end
    end

endmodule

// File: hw/quick_spi_top.sv
`include "quick_spi_params.svh"

module quick_spi_top (
    input  logic                        s_axi_aclk,
    input  logic                        s_axi_aresetn,
    input  logic [`QSPI_ADDR_W-1:0]     s_axi_awaddr,
    input  logic [7:0]                  s_axi_awlen,
    input  logic [1:0]                  s_axi_awburst,
    input  logic                        s_axi_awvalid,
    output logic                        s_axi_awready,
    input  logic [`QSPI_DATA_W-1:0]     s_axi_wdata,
    input  logic [`QSPI_STRB_W-1:0]     s_axi_wstrb,
    input  logic                        s_axi_wlast,
    input  logic                        s_axi_wvalid,
    output logic                        s_axi_wready,
    output logic [1:0]                  s_axi_bresp,
    output logic                        s_axi_bvalid,
    input  logic                        s_axi_bready,
    input  logic [`QSPI_ADDR_W-1:0]     s_axi_araddr,
    input  logic [7:0]                  s_axi_arlen,
    input  logic [1:0]                  s_axi_arburst,
    input  logic                        s_axi_arvalid,
    output logic                        s_axi_arready,
    output logic [`QSPI_DATA_W-1:0]     s_axi_rdata,
    output logic [1:0]                  s_axi_rresp,
    output logic                        s_axi_rlast,
    output logic                        s_axi_rvalid,
    input  logic                        s_axi_rready,
    output logic                        sclk,
    output logic                        mosi,
    output logic [`QSPI_NUM_SLAVES-1:0] ss_n
);

    logic                         wr_en;
    logic [`QSPI_WORD_IDX_W-1:0]  wr_word;
    logic [`QSPI_DATA_W-1:0]      wr_data;
    logic [`QSPI_STRB_W-1:0]      wr_strb;
    logic                         rd_en;
    logic [`QSPI_WORD_IDX_W-1:0]  rd_word;
    logic [`QSPI_DATA_W-1:0]      rd_data;
    quick_spi_pkg::spi_cfg_word_u cfg_word;
    logic [`QSPI_CNT_W-1:0]       elem_count;
    logic [`QSPI_CNT_W-1:0]       extra_toggles;
    logic [7:0]                   tx_byte;
    logic [`QSPI_WORD_IDX_W+1:0]  tx_byte_idx;
    logic                         xfer_done;

    axi_burst_decode u_decode (
        .s_axi_aclk, .s_axi_aresetn,
        .s_axi_awaddr, .s_axi_awlen, .s_axi_awburst, .s_axi_awvalid, .s_axi_awready,
        .s_axi_wdata, .s_axi_wstrb, .s_axi_wlast, .s_axi_wvalid, .s_axi_wready,
        .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
        .s_axi_araddr, .s_axi_arlen, .s_axi_arburst, .s_axi_arvalid, .s_axi_arready,
        .s_axi_rdata, .s_axi_rresp, .s_axi_rlast, .s_axi_rvalid, .s_axi_rready,
        .wr_en, .wr_word, .wr_data, .wr_strb, .rd_en, .rd_word, .rd_data
    );

    spi_buffer_mem u_buffer (
        .s_axi_aclk, .s_axi_aresetn,
        .wr_en, .wr_word, .wr_data, .wr_strb, .rd_en, .rd_word,
        .tx_byte_idx, .xfer_done,
        .rd_data, .cfg_word, .elem_count, .extra_toggles, .tx_byte
    );

    spi_shift_engine u_engine (
        .s_axi_aclk, .s_axi_aresetn,
        .hold (wr_en), // freeze on any write beat
        .cfg_word, .elem_count, .extra_toggles, .tx_byte,
        .tx_byte_idx, .xfer_done, .sclk, .mosi, .ss_n
    );

endmodule

// File: test/quick_spi_chk.sv
`include "quick_spi_params.svh"

module quick_spi_chk (
    input logic                        s_axi_aclk,
    input logic                        s_axi_aresetn,
    input logic                        s_axi_awready,
    input logic                        s_axi_arready,
    input logic                        s_axi_bvalid,
    input logic                        s_axi_bready,
    input logic                        s_axi_rvalid,
    input logic                        s_axi_rready,
    input logic [`QSPI_DATA_W-1:0]     s_axi_rdata,
    input logic                        s_axi_rlast,
    input logic [`QSPI_NUM_SLAVES-1:0] ss_n
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count; // failed assertions so far

    select_one_low: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        $onehot0(~ss_n))
        else begin
            fail_count++;
            $error("more than one slave select line is low");
        end

    awready_pulse: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_awready |=> !s_axi_awready)
        else begin
            fail_count++;
            $error("awready held longer than one cycle");
        end

    arready_pulse: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_arready |=> !s_axi_arready)
        else begin
            fail_count++;
            $error("arready held longer than one cycle");
        end

    // response stays put until the host takes it
    bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else begin
            fail_count++;
            $error("write response dropped before bready");
        end

    rvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=>
            s_axi_rvalid && $stable(s_axi_rdata) && $stable(s_axi_rlast))
        else begin
            fail_count++;
            $error("read data dropped or changed before rready");
        end

endmodule

bind quick_spi_top quick_spi_chk u_chk (.*);

// File: test/quick_spi_tb.sv
`include "quick_spi_params.svh"

module quick_spi_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 1000; // cycles per wait

    logic                        s_axi_aclk = 1'b0;
    logic                        s_axi_aresetn;
    logic [`QSPI_ADDR_W-1:0]     s_axi_awaddr;
    logic [`QSPI_ADDR_W-1:0]     s_axi_araddr;
    logic [7:0]                  s_axi_awlen;
    logic [7:0]                  s_axi_arlen;
    logic [1:0]                  s_axi_awburst;
    logic [1:0]                  s_axi_arburst;
    logic [1:0]                  s_axi_bresp;
    logic [1:0]                  s_axi_rresp;
    logic [`QSPI_DATA_W-1:0]     s_axi_wdata;
    logic [`QSPI_DATA_W-1:0]     s_axi_rdata;
    logic [`QSPI_STRB_W-1:0]     s_axi_wstrb;
    logic                        s_axi_awvalid;
    logic                        s_axi_awready;
    logic                        s_axi_wlast;
    logic                        s_axi_wvalid;
    logic                        s_axi_wready;
    logic                        s_axi_bvalid;
    logic                        s_axi_bready;
    logic                        s_axi_arvalid;
    logic                        s_axi_arready;
    logic                        s_axi_rlast;
    logic                        s_axi_rvalid;
    logic                        s_axi_rready;
    logic                        sclk;
    logic                        mosi;
    logic [`QSPI_NUM_SLAVES-1:0] ss_n;

    logic [7:0]                  model_mem [0:`QSPI_MEM_BYTES-1];
    logic [31:0]                 beat_data [0:15];
    logic [3:0]                  beat_strb [0:15];
    logic [31:0]                 rd_beats [0:15];
    logic [63:0]                 stream;     // bit i is the i-th sampled mosi bit
    logic [`QSPI_NUM_SLAVES-1:0] exp_ss;
    bit                          stall_en;
    bit                          mon_armed;
    bit                          in_win;
    bit                          prev_sclk;
    bit                          mon_cpol;
    bit                          mon_cpha;
    int                          bits_per_win;
    int                          extra_n;
    int                          win_edges;
    int                          win_count;
    int                          bit_count;

    quick_spi_top DUT (.*);

    always #2 s_axi_aclk = ~s_axi_aclk;

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0d ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            stop_run();
        end
    endtask

    task automatic step_cycle(inout int n, input string what);
        @(posedge s_axi_aclk);
        n++;
        if (n > TIMEOUT) begin
            $display("Timeout while waiting for %s", what);
            stop_run();
        end
    endtask

    function automatic logic [31:0] model_word(input logic [3:0] w);
        return {model_mem[4*w+3], model_mem[4*w+2], model_mem[4*w+1], model_mem[4*w]};
    endfunction

    task automatic axi_write(input logic [7:0] addr, input int len, input logic [1:0] burst);
        int         n;
        logic [3:0] w;
        s_axi_awaddr  <= addr;
        s_axi_awlen   <= 8'(len);
        s_axi_awburst <= burst;
        s_axi_awvalid <= 1'b1;
        n = 0;
        do begin
            step_cycle(n, "awready");
        end while (!s_axi_awready);
        s_axi_awvalid <= 1'b0;
        for (int i = 0; i <= len; i++) begin
            s_axi_wdata  <= beat_data[i];
            s_axi_wstrb  <= beat_strb[i];
            s_axi_wlast  <= (i == len);
            s_axi_wvalid <= 1'b1;
            n = 0;
            do begin
                step_cycle(n, "wready");
            end while (!s_axi_wready);
        end
        s_axi_wvalid <= 1'b0;
        s_axi_wlast  <= 1'b0;
        n = 0;
        do begin
            s_axi_bready <= stall_en ? 1'($urandom % 2) : 1'b1;
            step_cycle(n, "write response");
        end while (!(s_axi_bvalid && s_axi_bready));
        s_axi_bready <= 1'b0;
        check_equal(s_axi_bresp, 2'b00, "bresp");
        // strobe merge where FIXED stays on one word
        w = addr[5:2];
        for (int i = 0; i <= len; i++) begin
            for (int b = 0; b < 4; b++) begin
                if (beat_strb[i][b]) begin
                    model_mem[4*w+b] = beat_data[i][8*b +: 8];
                end
            end
            if (burst != quick_spi_pkg::FIXED) begin
                w++;
            end
        end
    endtask

    task automatic axi_read(input logic [7:0] addr, input int len, input logic [1:0] burst);
        int n;
        s_axi_araddr  <= addr;
        s_axi_arlen   <= 8'(len);
        s_axi_arburst <= burst;
        s_axi_arvalid <= 1'b1;
        n = 0;
        do begin
            step_cycle(n, "arready");
        end while (!s_axi_arready);
        s_axi_arvalid <= 1'b0;
        for (int i = 0; i <= len; i++) begin
            n = 0;
            do begin
                s_axi_rready <= stall_en ? 1'($urandom % 2) : 1'b1;
                step_cycle(n, "read data");
            end while (!(s_axi_rvalid && s_axi_rready));
            rd_beats[i] = s_axi_rdata;
            check_equal(s_axi_rlast, (i == len), "rlast");
            check_equal(s_axi_rresp, 2'b00, "rresp");
        end
        s_axi_rready <= 1'b0;
    endtask

    task automatic read_compare(input logic [7:0] addr, input int len, input logic [1:0] burst);
        logic [3:0] w;
        axi_read(addr, len, burst);
        w = addr[5:2];
        for (int i = 0; i <= len; i++) begin
            check_equal(rd_beats[i], model_word(w), $sformatf("readback of word %0d", w));
            if (burst != quick_spi_pkg::FIXED) begin
                w++;
            end
        end
    endtask

    task automatic fill_random(input int len);
        for (int i = 0; i <= len; i++) begin
            beat_data[i] = $urandom;
            beat_strb[i] = 4'($urandom);
        end
    endtask

    // spi monitor samples mid-cycle
    always @(negedge s_axi_aclk) begin
        if (mon_armed) begin
            if (ss_n !== '1) begin
                if (!in_win) begin
                    in_win    = 1'b1;
                    win_edges = 0;
                    win_count++;
                    check_equal(ss_n, exp_ss, "selected slave line");
                end
                if (sclk !== prev_sclk) begin
                    // even edges lead, odd edges trail
                    if (win_edges < 2 * bits_per_win && win_edges % 2 == int'(mon_cpha)) begin
                        stream[bit_count] = mosi;
                        bit_count++;
                    end
                    win_edges++;
                end
            end else begin
                if (in_win) begin
                    check_equal(win_edges, 2 * bits_per_win + extra_n, "sclk edges in window");
                end
                in_win = 1'b0;
                check_equal(sclk, mon_cpol, "sclk rest level");
                check_equal(mosi === 1'bz, 1'b1, "mosi released outside window");
            end
        end
        prev_sclk = sclk;
    end

    // bound protocol assertions
    always @(negedge s_axi_aclk) begin
        check_equal(DUT.u_chk.fail_count, 0, "failed protocol assertions");
    end

    task automatic run_case(input int cpol, input int cpha, input int burst, input int slave,
                            input int size, input int count, input int extra,
                            input logic [31:0] tx, input int exp_bits,
                            input logic [63:0] exp_stream, input int exp_wins);
        logic [7:0] ctrl;
        int         n;
        ctrl = 8'(cpol | (cpha << 1) | (burst << 3));
        beat_data[0] = {16'(size), 8'(slave), ctrl};
        beat_data[1] = 32'(count);
        beat_data[2] = 32'(extra);
        beat_data[3] = tx;
        for (int i = 0; i < 4; i++) begin
            beat_strb[i] = 4'hf;
        end
        axi_write(8'h00, 3, quick_spi_pkg::INCR);
        stream        = '0;
        bit_count     = 0;
        win_count     = 0;
        in_win        = 1'b0;
        bits_per_win  = (burst != 0) ? size * count : size;
        extra_n       = extra;
        mon_cpol      = cpol[0];
        mon_cpha      = cpha[0];
        exp_ss        = '1;
        exp_ss[slave] = 1'b0; // only the chosen line low
        mon_armed     = 1'b1;
        beat_data[0] = {24'h0, ctrl | 8'h04}; // start bit alone
        beat_strb[0] = 4'h1;
        axi_write(8'h00, 0, quick_spi_pkg::INCR);
        n = 0;
        do begin
            step_cycle(n, "start bit to clear");
            axi_read(8'h00, 0, quick_spi_pkg::INCR);
        end while (rd_beats[0][2]);
        mon_armed = 1'b0;
        model_mem[0][2] = 1'b0;
        check_equal(rd_beats[0], model_word(0), "configuration word after transfer");
        check_equal(bit_count, exp_bits, "mosi bit count");
        check_equal(bit_count, size * count, "bits versus elem_count times elem_size");
        check_equal(stream & ((64'd1 << exp_bits) - 1), exp_stream, "mosi bit stream");
        check_equal(win_count, exp_wins, "select window count");
    endtask

    initial begin
        int          fd;
        int          n;
        int          cases;
        int          cpol;
        int          cpha;
        int          burst;
        int          slave;
        int          size;
        int          count;
        int          extra;
        int          bits;
        int          wins;
        logic [31:0] tx;
        logic [63:0] exp_stream;
        string       line;
        void'($urandom(98));
        s_axi_aresetn = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awlen   = '0;
        s_axi_awburst = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wlast   = 1'b0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arlen   = '0;
        s_axi_arburst = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        repeat (2) @(posedge s_axi_aclk);
        s_axi_aresetn <= 1'b1;
        @(posedge s_axi_aclk);

        // whole buffer with the start bit kept clear
        for (int a = 0; a < `QSPI_MEM_BYTES; a++) begin
            beat_data[a / 4][8 * (a % 4) +: 8] = 8'(a * 29 + 90) & ((a == 0) ? 8'hfb : 8'hff);
            beat_strb[a / 4] = 4'hf;
        end
        axi_write(8'h00, 15, quick_spi_pkg::INCR);
        read_compare(8'h00, 15, quick_spi_pkg::INCR);

        fill_random(4);
        axi_write(8'h08, 4, quick_spi_pkg::INCR);
        read_compare(8'h04, 6, quick_spi_pkg::INCR);

        fill_random(2);
        axi_write(8'h24, 2, quick_spi_pkg::FIXED);
        read_compare(8'h20, 2, quick_spi_pkg::INCR);
        read_compare(8'h24, 2, quick_spi_pkg::FIXED);

        stall_en = 1'b1;
        repeat (6) begin
            n = $urandom % 6;
            fill_random(n);
            tx = 32'((($urandom % 9) + 1) * 4);
            axi_write(tx[7:0], n, quick_spi_pkg::INCR);
            read_compare(tx[7:0], n, quick_spi_pkg::INCR);
        end
        stall_en = 1'b0;

        cases = 0;
        fd = $fopen("test/quick_spi_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file test/quick_spi_input.txt");
            stop_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %d %d %h %d %h %d", cpol, cpha, burst,
                            slave, size, count, extra, tx, bits, exp_stream, wins);
                if (n != 11) begin
                    $display("Malformed line in the stimulus file: %s", line);
                    stop_run();
                end
                run_case(cpol, cpha, burst, slave, size, count, extra, tx, bits,
                         exp_stream, wins);
                cases++;
            end
        end
        $fclose(fd);
        check_equal(cases > 0, 1'b1, "cases read from the stimulus file");
        @(negedge s_axi_aclk);
        check_equal(DUT.u_chk.fail_count, 0, "failed protocol assertions");

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: test/quick_spi_input.txt
# cpol cpha burst slave elem_size elem_count extra_toggles tx_word (hex, bytes 12..15)
# then mosi bit count, bit stream (hex, first bit in bit 0), select window count
0 0 1 0 8 2 0 1234c3a5 16 c3a5 1
0 1 1 1 8 2 0 00005a3c 16 5a3c 1
1 0 1 0 6 3 0 abc30f69 18 30f69 1
1 1 1 1 12 2 0 8e1b7d24 24 1b7d24 1
0 0 0 0 8 3 0 00c35a96 24 c35a96 3
1 1 0 1 5 4 0 deadbeef 20 dbeef 4
0 1 1 0 8 2 3 00009c71 16 9c71 1
1 0 0 1 4 3 2 00000f3a 12 f3a 3
0 0 1 1 32 1 5 13579bdf 32 13579bdf 1
1 1 0 0 3 5 1 00006d2b 15 6d2b 5
0 1 0 1 8 1 4 000000b7 8 b7 1
1 0 1 0 1 7 0 00000055 7 55 1

// File: compile.f
+incdir+include
hw/quick_spi_pkg.sv
hw/axi_burst_decode.sv
hw/spi_buffer_mem.sv
hw/spi_shift_engine.sv
hw/quick_spi_top.sv
test/quick_spi_chk.sv
test/quick_spi_tb.sv
